/* fir_periph.f */
ahb_pkg.sv
fir_pkg.sv
tap_counter.sv
fir_datapath.sv
fir_control.sv
ahb_fir_slave.sv
fir_periph_top.sv
tb_fir_periph.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of tb_fir_periph.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_fir_periph \
    -f fir_periph.f -o sim_fir_periph > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_fir_periph > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"
exit 0

/* tb_fir_periph.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fir_periph;
    import ahb_pkg::*;
    import fir_pkg::*;

    localparam logic [1:0] TRANS_NONSEQ = 2'b10;
    localparam int         IDLE_POLLS   = 40;

    logic        clk;
    logic        rst_n;
    ahb_req_t    bus_req;
    ahb_rsp_t    bus_rsp;
    integer      seed;
    sample_t     model_coeff [4];
    sample_t     model_hist [4];   // Entry k is the sample from k steps ago.
    logic [15:0] model_res;
    logic        model_err;

    fir_periph_top fir_periph_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp) else begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    // One single-cycle transfer, response sampled mid-cycle once registered.
    task automatic bus_xfer(input logic wr, input logic [3:0] addr, input logic size,
                            input logic [15:0] wdata, output ahb_rsp_t rsp);
        ahb_req_t r;
        r       = '0;
        r.sel   = 1'b1;
        r.addr  = addr;
        r.size  = size;
        r.trans = TRANS_NONSEQ;
        r.write = wr;
        r.wdata = wdata;
        @(posedge clk);
        bus_req <= r;
        @(posedge clk);
        bus_req <= '0;
        @(negedge clk);
        rsp = bus_rsp;
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic size,
                             input logic [15:0] wdata, output logic resp);
        ahb_rsp_t rsp;
        bus_xfer(1'b1, addr, size, wdata, rsp);
        resp = rsp.resp;
    endtask

    task automatic bus_read(input logic [3:0] addr, input logic size,
                            output logic [15:0] data, output logic resp);
        ahb_rsp_t rsp;
        bus_xfer(1'b0, addr, size, 16'h0000, rsp);
        data = rsp.rdata;
        resp = rsp.resp;
    endtask

    task automatic write_ok(input string name, input logic [3:0] addr, input logic size,
                            input logic [15:0] wdata);
        logic resp;
        bus_write(addr, size, wdata, resp);
        check_val({name, " write resp"}, 16'h0000, {15'b0, resp});
    endtask

    task automatic check_rd(input string name, input logic [3:0] addr, input logic size,
                            input logic [15:0] exp);
        logic [15:0] data;
        logic        resp;
        bus_read(addr, size, data, resp);
        check_val({name, " read resp"}, 16'h0000, {15'b0, resp});
        check_val(name, exp, data);
    endtask

    task automatic expect_err(input string name, input logic wr, input logic [3:0] addr,
                              input logic size, input logic [15:0] wdata);
        ahb_rsp_t rsp;
        bus_xfer(wr, addr, size, wdata, rsp);
        check_val(name, 16'h0001, {15'b0, rsp.resp});
    endtask

    task automatic wait_idle(input string name);
        logic [15:0] st;
        logic        resp;
        int          polls;
        polls = 0;
        st    = 16'h0001;
        while (st[0]) begin
            if (polls == IDLE_POLLS) begin
                $display("ERRORS FOUND");
                $fatal(1, "%s: busy bit never cleared after %0d status polls", name, polls);
            end
            bus_read(ADDR_STATUS, SIZE_HALF, st, resp);
            check_val({name, " status resp"}, 16'h0000, {15'b0, resp});
            polls++;
        end
    endtask

    task automatic model_push(input sample_t s);
        longint sum;
        for (int k = 3; k > 0; k--) begin
            model_hist[k] = model_hist[k-1];
        end
        model_hist[0] = s;
        sum = 0;
        for (int k = 0; k < 4; k++) begin
            sum = sum + longint'(model_coeff[k]) * longint'(model_hist[k]);
        end
        model_res = sum[15:0];
        model_err = (sum > 32767) || (sum < -32768);
    endtask

    task automatic send_sample(input string name, input sample_t s);
        logic [15:0] exp_st;
        write_ok(name, ADDR_SAMPLE, SIZE_HALF, s);
        model_push(s);
        wait_idle(name);
        exp_st                 = '0;
        exp_st[STATUS_ERR_BIT] = model_err;
        check_rd({name, " result"}, ADDR_RESULT, SIZE_HALF, model_res);
        check_rd({name, " status"}, ADDR_STATUS, SIZE_HALF, exp_st);
    endtask

    task automatic load_coeffs(input string name, input logic [3:0][15:0] c);
        logic [15:0] st;
        logic        resp;
        for (int k = 0; k < 4; k++) begin
            write_ok(name, ADDR_COEFF0 + 4'(2 * k), SIZE_HALF, c[k]);
        end
        write_ok(name, ADDR_NEW_COEFF, SIZE_HALF, 16'h0001);
        bus_read(ADDR_STATUS, SIZE_HALF, st, resp);
        check_val({name, " busy resp"}, 16'h0000, {15'b0, resp});
        check_val({name, " busy"}, 16'h0001, {15'b0, st[0]});
        wait_idle(name);
        check_rd({name, " flag"}, ADDR_NEW_COEFF, SIZE_HALF, 16'h0000);
        for (int k = 0; k < 4; k++) begin
            model_coeff[k] = c[k];
            check_rd({name, " coeff"}, ADDR_COEFF0 + 4'(2 * k), SIZE_HALF, c[k]);
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_val("reset resp", 16'h0000, {15'b0, bus_rsp.resp});
        check_rd("reset status", ADDR_STATUS, SIZE_HALF, 16'h0000);
        check_rd("reset result", ADDR_RESULT, SIZE_HALF, 16'h0000);
        check_rd("reset sample", ADDR_SAMPLE, SIZE_HALF, 16'h0000);
        check_rd("reset flag", ADDR_NEW_COEFF, SIZE_HALF, 16'h0000);
        for (int k = 0; k < 4; k++) begin
            check_rd("reset coeff", ADDR_COEFF0 + 4'(2 * k), SIZE_HALF, 16'h0000);
        end
    endtask

    task automatic test_reg_access();
        write_ok("reg_access", ADDR_COEFF0, SIZE_HALF, 16'h1234);
        check_rd("reg_access coeff0 half", ADDR_COEFF0, SIZE_HALF, 16'h1234);
        write_ok("reg_access", ADDR_COEFF0 + 4'd1, SIZE_BYTE, 16'hAB00);  // High lane only.
        check_rd("reg_access coeff0 merged", ADDR_COEFF0, SIZE_HALF, 16'hAB34);
        check_rd("reg_access coeff0 hi byte", ADDR_COEFF0 + 4'd1, SIZE_BYTE, 16'hAB00);
        check_rd("reg_access coeff0 lo byte", ADDR_COEFF0, SIZE_BYTE, 16'h0034);
        write_ok("reg_access", 4'd12, SIZE_BYTE, 16'hFFCD);
        check_rd("reg_access coeff3 lo write", 4'd12, SIZE_HALF, 16'h00CD);
        send_sample("reg_access sample", 16'h1357);
        check_rd("reg_access sample half", ADDR_SAMPLE, SIZE_HALF, 16'h1357);
        write_ok("reg_access", ADDR_SAMPLE, SIZE_BYTE, 16'h775A);
        write_ok("reg_access", ADDR_SAMPLE + 4'd1, SIZE_BYTE, 16'hA566);
        check_rd("reg_access sample bytes", ADDR_SAMPLE, SIZE_HALF, 16'hA55A);
        check_rd("reg_access sample hi byte", ADDR_SAMPLE + 4'd1, SIZE_BYTE, 16'hA500);
        expect_err("reg_access write status", 1'b1, ADDR_STATUS, SIZE_HALF, 16'hFFFF);
        expect_err("reg_access write status byte", 1'b1, 4'd1, SIZE_BYTE, 16'hFFFF);
        expect_err("reg_access write result", 1'b1, ADDR_RESULT, SIZE_HALF, 16'hFFFF);
        expect_err("reg_access write result byte", 1'b1, 4'd3, SIZE_BYTE, 16'hFFFF);
        expect_err("reg_access byte write 15", 1'b1, 4'd15, SIZE_BYTE, 16'h0101);
        check_rd("reg_access flag kept", ADDR_NEW_COEFF, SIZE_HALF, 16'h0000);
        expect_err("reg_access byte read 15", 1'b0, 4'd15, SIZE_BYTE, 16'h0000);
        check_rd("reg_access coeff1 kept", ADDR_COEFF0 + 4'd2, SIZE_HALF, 16'h0000);
        check_rd("reg_access coeff2 kept", ADDR_COEFF0 + 4'd4, SIZE_HALF, 16'h0000);
        check_rd("reg_access sample kept", ADDR_SAMPLE, SIZE_HALF, 16'hA55A);
    endtask

    task automatic test_filter();
        logic [31:0] rnd;
        load_coeffs("coeff_load", {16'h0002, 16'h0007, 16'hFFFD, 16'h0005});  // c3 down to c0.
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            send_sample($sformatf("filter sample %0d", i), rnd[15:0]);
        end
        check_rd("filter result hi byte", ADDR_RESULT + 4'd1, SIZE_BYTE,
                 {model_res[15:8], 8'h00});
        check_rd("filter result lo byte", ADDR_RESULT, SIZE_BYTE, {8'h00, model_res[7:0]});
    endtask

    task automatic test_overflow();
        load_coeffs("overflow", {16'h0000, 16'h0000, 16'h0000, 16'h7000});
        send_sample("overflow positive", 16'h7000);
        send_sample("overflow clear", 16'h0001);
        send_sample("overflow negative", 16'h9000);
        send_sample("overflow clear again", 16'h0000);
    endtask

    initial begin
        rst_n     = 1'b0;
        bus_req   = '0;
        seed      = 32'h4f2f;
        model_res = '0;
        model_err = 1'b0;
        for (int k = 0; k < 4; k++) begin
            model_coeff[k] = '0;
            model_hist[k]  = '0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_reg_access();
        test_filter();
        test_overflow();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* fir_periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_periph_top (
    input  logic              clk,
    input  logic              rst_n,
    input  ahb_pkg::ahb_req_t bus_req,
    output ahb_pkg::ahb_rsp_t bus_rsp
);
    import fir_pkg::*;

    sample_xfer_t sample_xfer;
    coeff_load_t  coeff_load;
    sample_t      fir_out;
    logic         sample_ack;
    logic         new_coeff;
    logic         loading;
    logic         shift;
    logic         accumulate;
    logic         result_write;
    logic         modwait;
    logic         err;
    logic         tap_last;
    logic         count_en;
    logic         count_clr;
    logic [1:0]   idx;

    ahb_fir_slave ahb_fir_slave_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .sample_xfer (sample_xfer),
        .sample_ack  (sample_ack),
        .new_coeff   (new_coeff),
        .coeff_idx   (idx),
        .loading     (loading),
        .coeff_load  (coeff_load),
        .modwait     (modwait),
        .fir_out     (fir_out),
        .err         (err)
    );

    fir_control fir_control_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_coeff    (new_coeff),
        .sample_req   (sample_xfer.req),
        .sample_ack   (sample_ack),
        .loading      (loading),
        .shift        (shift),
        .accumulate   (accumulate),
        .result_write (result_write),
        .modwait      (modwait),
        .tap_last     (tap_last),
        .count_en     (count_en),
        .count_clr    (count_clr)
    );

    tap_counter tap_counter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .count_en  (count_en),
        .count_clr (count_clr),
        .idx       (idx),
        .tap_last  (tap_last)
    );

    fir_datapath fir_datapath_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .coeff_load   (coeff_load),
        .sample       (sample_xfer.sample),
        .shift        (shift),
        .accumulate   (accumulate),
        .result_write (result_write),
        .tap_idx      (idx),
        .fir_out      (fir_out),
        .err          (err)
    );

endmodule

`default_nettype wire

/* ahb_fir_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module ahb_fir_slave (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ahb_pkg::ahb_req_t     bus_req,
    output ahb_pkg::ahb_rsp_t     bus_rsp,
    output fir_pkg::sample_xfer_t sample_xfer,
    input  logic                  sample_ack,
    output logic                  new_coeff,
    input  logic [1:0]            coeff_idx,
    input  logic                  loading,
    output fir_pkg::coeff_load_t  coeff_load,
    input  logic                  modwait,
    input  fir_pkg::sample_t      fir_out,
    input  logic                  err
);
    import ahb_pkg::*;
    import fir_pkg::*;

    logic       active;
    logic       byte_acc;
    logic [2:0] region;      // Word index within the map.
    logic [2:0] coeff_off;
    logic [1:0] cidx;
    logic       bad;
    logic       wr_ok;
    logic       sample_wr;
    logic       busy;
    half_u      cur;
    half_u      merged;
    half_u      rd_val;
    sample_t    sample_reg;
    coeff_t     coeff_reg [4];
    logic       req;
    logic       pend;        // Sample written while the controller still holds ack.

    assign active    = bus_req.sel && (bus_req.trans != TRANS_IDLE);
    assign byte_acc  = (bus_req.size == SIZE_BYTE);
    assign region    = bus_req.addr[3:1];
    assign coeff_off = region - ADDR_COEFF0[3:1];
    assign cidx      = coeff_off[1:0];
    assign busy      = new_coeff || modwait || req || pend;

    assign bad = active && ((bus_req.write && (region <= ADDR_RESULT[3:1])) ||
                            (byte_acc && (bus_req.addr == ADDR_NEW_COEFF + 4'd1)));
    assign wr_ok     = active && bus_req.write && !bad;
    assign sample_wr = wr_ok && (region == ADDR_SAMPLE[3:1]) && (bus_req.size == SIZE_HALF);

    always_comb begin
        cur.word = '0;
        case (region)
            ADDR_STATUS[3:1]: begin
                cur.word[0]              = busy;
                cur.word[STATUS_ERR_BIT] = err;
            end
            ADDR_RESULT[3:1]:    cur.word = fir_out;
            ADDR_SAMPLE[3:1]:    cur.word = sample_reg;
            ADDR_NEW_COEFF[3:1]: cur.word = {15'b0, new_coeff};
            default:             cur.word = coeff_reg[cidx];
        endcase
    end

    // Byte lanes for writes and reads.
    always_comb begin
        merged      = cur;
        rd_val.word = '0;
        if (!byte_acc) begin
            merged.word = bus_req.wdata;
            rd_val      = cur;
        end else if (bus_req.addr[0]) begin
            merged.bytes.hi = bus_req.wdata[15:8];
            rd_val.bytes.hi = cur.bytes.hi;
        end else begin
            merged.bytes.lo = bus_req.wdata[7:0];
            rd_val.bytes.lo = cur.bytes.lo;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_rsp    <= '0;
            sample_reg <= '0;
            new_coeff  <= 1'b0;
            req        <= 1'b0;
            pend       <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                coeff_reg[i] <= '0;
            end
        end else begin
            bus_rsp.resp <= bad;
            if (active && !bus_req.write && !bad) begin
                bus_rsp.rdata <= rd_val.word;
            end
            if (loading && (coeff_idx == 2'd3)) begin
                new_coeff <= 1'b0;  // Last coefficient is on its way.
            end
            if (wr_ok) begin
                case (region)
                    ADDR_SAMPLE[3:1]:    sample_reg <= merged.word;
                    ADDR_NEW_COEFF[3:1]: new_coeff <= bus_req.wdata[0];
                    default:             coeff_reg[cidx] <= merged.word;
                endcase
            end
            if (req && sample_ack) begin
                req <= 1'b0;
            end else if (!req && !sample_ack && (pend || sample_wr)) begin
                req <= 1'b1;
            end
            if (sample_wr && sample_ack) begin
                pend <= 1'b1;
            end else if (!req && !sample_ack) begin
                pend <= 1'b0;
            end
        end
    end

    assign sample_xfer.req    = req;
    assign sample_xfer.sample = sample_reg;
    assign coeff_load.valid   = loading;
    assign coeff_load.num     = coeff_idx;
    assign coeff_load.coeff   = coeff_reg[coeff_idx];

    // Controller keeps ack up until req has been released.
    a_ack_held : assert property (@(posedge clk) disable iff (!rst_n)
        $fell(sample_ack) |-> !$past(req));

endmodule

`default_nettype wire

/* fir_control.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_control (
    input  logic clk,
    input  logic rst_n,
    input  logic new_coeff,
    input  logic sample_req,
    output logic sample_ack,
    output logic loading,
    output logic shift,
    output logic accumulate,
    output logic result_write,
    output logic modwait,
    input  logic tap_last,
    output logic count_en,
    output logic count_clr
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_ACK,
        ST_ACCUM,
        ST_WRITE,
        ST_RELEASE
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next   = state;
        loading      = 1'b0;
        shift        = 1'b0;
        accumulate   = 1'b0;
        result_write = 1'b0;
        modwait      = 1'b0;
        count_en     = 1'b0;
        count_clr    = 1'b0;
        case (state)
            ST_IDLE: begin
                count_clr = 1'b1;
                if (new_coeff) begin
                    state_next = ST_LOAD;  // Loads win over a waiting sample.
                end else if (sample_req) begin
                    state_next = ST_ACK;
                end
            end
            ST_LOAD: begin
                loading  = 1'b1;
                count_en = 1'b1;
                if (tap_last) begin
                    state_next = ST_IDLE;
                end
            end
            ST_ACK: begin
                shift      = 1'b1;  // Sample enters the delay line.
                modwait    = 1'b1;
                state_next = ST_ACCUM;
            end
            ST_ACCUM: begin
                accumulate = 1'b1;
                count_en   = 1'b1;
                modwait    = 1'b1;
                if (tap_last) begin
                    state_next = ST_WRITE;
                end
            end
            ST_WRITE: begin
                result_write = 1'b1;
                modwait      = 1'b1;
                state_next   = ST_RELEASE;
            end
            ST_RELEASE: begin
                if (!sample_ack) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            sample_ack <= 1'b0;
        end else begin
            state <= state_next;
            if ((state == ST_IDLE) && (state_next == ST_ACK)) begin
                sample_ack <= 1'b1;
            end else if (!sample_req) begin
                sample_ack <= 1'b0;
            end
        end
    end

    // A coefficient load lasts exactly four cycles.
    a_load_len : assert property (@(posedge clk) disable iff (!rst_n)
        $fell(loading) |-> ($past(loading, 2) && $past(loading, 3) && $past(loading, 4)
                            && !$past(loading, 5)));

endmodule

`default_nettype wire

/* fir_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fir_pkg::coeff_load_t coeff_load,
    input  fir_pkg::sample_t     sample,
    input  logic                 shift,
    input  logic                 accumulate,
    input  logic                 result_write,
    input  logic [1:0]           tap_idx,
    output fir_pkg::sample_t     fir_out,
    output logic                 err
);
    import fir_pkg::*;

    coeff_t             coeff_bank [4];
    sample_t            delay_line [4];  // Entry k is the sample from k steps ago.
    logic signed [33:0] acc;
    logic signed [31:0] product;
    logic               in_range;

    assign product = coeff_bank[tap_idx] * delay_line[tap_idx];

    // Sum fits in 16 bits when all upper bits match the sign.
    assign in_range = (&acc[33:15]) || !(|acc[33:15]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc     <= '0;
            fir_out <= '0;
            err     <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                coeff_bank[i] <= '0;
                delay_line[i] <= '0;
            end
        end else begin
            if (coeff_load.valid) begin
                coeff_bank[coeff_load.num] <= coeff_load.coeff;
            end
            if (shift) begin
                delay_line[0] <= sample;
                for (int k = 1; k < 4; k++) begin
                    delay_line[k] <= delay_line[k-1];
                end
                acc <= '0;  // Fresh sum per sample.
            end else if (accumulate) begin
                acc <= acc + product;
            end
            if (result_write) begin
                fir_out <= sample_t'(acc[15:0]);
                err     <= !in_range;
            end
        end
    end

endmodule

`default_nettype wire

/* tap_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module tap_counter (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       count_en,
    input  logic       count_clr,
    output logic [1:0] idx,
    output logic       tap_last
);

    // Shared by coefficient loading and the tap loop.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx <= 2'd0;
        end else if (count_clr) begin
            idx <= 2'd0;
        end else if (count_en) begin
            idx <= idx + 2'd1;  // Wraps after the fourth tap.
        end
    end

    assign tap_last = (idx == 2'd3);

endmodule

`default_nettype wire

/* fir_pkg.sv */
`default_nettype none

package fir_pkg;

    typedef logic signed [15:0] sample_t;
    typedef logic signed [15:0] coeff_t;

    typedef struct packed {
        logic    req;
        sample_t sample;
    } sample_xfer_t;

    typedef struct packed {
        logic       valid;   // Coefficient load in this cycle.
        logic [1:0] num;
        coeff_t     coeff;
    } coeff_load_t;

    // Register map, two byte addresses per word.
    localparam logic [3:0] ADDR_STATUS    = 4'd0;
    localparam logic [3:0] ADDR_RESULT    = 4'd2;
    localparam logic [3:0] ADDR_SAMPLE    = 4'd4;
    localparam logic [3:0] ADDR_COEFF0    = 4'd6;
    localparam logic [3:0] ADDR_NEW_COEFF = 4'd14;

    // Busy sits in bit 0 of the status word.
    localparam int STATUS_ERR_BIT = 8;

endpackage

`default_nettype wire

/* ahb_pkg.sv */
`default_nettype none

package ahb_pkg;

    localparam logic       SIZE_BYTE  = 1'b0;
    localparam logic       SIZE_HALF  = 1'b1;
    localparam logic [1:0] TRANS_IDLE = 2'b00;

    typedef struct packed {
        logic        sel;
        logic [3:0]  addr;
        logic        size;   // Byte or halfword.
        logic [1:0]  trans;
        logic        write;
        logic [15:0] wdata;
    } ahb_req_t;

    typedef struct packed {
        logic [15:0] rdata;
        logic        resp;   // High for an error response.
    } ahb_rsp_t;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } half_bytes_t;

    // One register word, seen whole or as two byte lanes.
    typedef union packed {
        logic [15:0] word;
        half_bytes_t bytes;
    } half_u;

endpackage

`default_nettype wire
